/* tart_top.f */
design/tart_pkg.sv
design/tart_buf_if.sv
design/tart_capture.sv
design/tart_acquire.sv
design/tart_buffer_arbiter.sv
design/tart_host_regs.sv
design/tart_top.sv
sim/tart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run; a $fatal in the testbench gives a failing exit status
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tart_tb -f tart_top.f --Mdir obj_dir -o tart_sim

./obj_dir/tart_sim

/* sim/tart_tb.sv */
module tart_tb;

    localparam int SAMPLE_DIV = 8;
    localparam int DEPTH_LOG2 = 4;
    localparam int DEPTH      = 2 ** DEPTH_LOG2;
    localparam int NROWS      = 30;

    // Status masks and control words
    localparam logic [7:0] FULL_M = 8'(1 << tart_pkg::STAT_FULL);
    localparam logic [7:0] ACQ_M  = 8'(1 << tart_pkg::STAT_ACQUIRING);
    localparam logic [7:0] OVF_M  = 8'(1 << tart_pkg::STAT_OVERFLOW);
    localparam logic [7:0] CNT_HI = 8'(DEPTH);                // Count bit at depth
    localparam logic [7:0] C_REAL = 8'((1 << tart_pkg::CTRL_CAP_EN) | (1 << tart_pkg::CTRL_ACQ_EN));
    localparam logic [7:0] C_FAKE = C_REAL | 8'(1 << tart_pkg::CTRL_FAKE);
    localparam logic [7:0] C_STOP = C_FAKE & ~8'(1 << tart_pkg::CTRL_ACQ_EN);

    typedef enum logic [3:0] {
        OP_WRITE,       // Write data
        OP_READ,        // Read and compare whole word
        OP_MASK,        // Read and compare masked bits
        OP_POLL,        // Read until a mask bit is set
        OP_RAND_CTRL,   // Random 2-bit CTRL write and readback
        OP_HELD,        // DEPTH DATA words equal to the antenna value
        OP_CHAIN,       // DEPTH DATA words in one LFSR chain
        OP_CONTEND      // DATA and STATUS reads until a mask bit is set
    } op_e;

    typedef struct packed {
        op_e                 op;
        tart_pkg::reg_addr_e addr;
        logic [7:0]          data;      // Write data or mask
        logic [7:0]          exp_val;
    } row_t;

    logic                clock_b;
    logic                rst_i;
    tart_pkg::antenna_t  antenna_i;
    logic                host_req_i;
    logic                host_we_i;
    tart_pkg::reg_addr_e host_addr_i;
    tart_pkg::reg_data_t host_wdata_i;
    logic                host_ack_o;
    tart_pkg::reg_data_t host_rdata_o;
    tart_pkg::antenna_t  ant_val;       // Held antenna value

    // ------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------
    row_t rows [NROWS] = '{
        '{OP_READ,      tart_pkg::REG_CTRL,   8'h00,  8'h00},   // Values after reset
        '{OP_READ,      tart_pkg::REG_STATUS, 8'h00,  8'h00},
        '{OP_READ,      tart_pkg::REG_COUNT,  8'h00,  8'h00},
        '{OP_RAND_CTRL, tart_pkg::REG_CTRL,   8'h00,  8'h00},
        '{OP_RAND_CTRL, tart_pkg::REG_CTRL,   8'h00,  8'h00},
        '{OP_RAND_CTRL, tart_pkg::REG_CTRL,   8'h00,  8'h00},
        '{OP_WRITE,     tart_pkg::REG_CTRL,   8'h00,  8'h00},
        '{OP_WRITE,     tart_pkg::REG_CTRL,   C_REAL, 8'h00},   // Real antenna run
        '{OP_POLL,      tart_pkg::REG_STATUS, FULL_M, 8'h00},
        '{OP_READ,      tart_pkg::REG_COUNT,  8'h00,  CNT_HI},
        '{OP_MASK,      tart_pkg::REG_STATUS, OVF_M | ACQ_M, 8'h00},   // Stopped, no drops
        '{OP_WRITE,     tart_pkg::REG_DATA,   8'h00,  8'h00},   // Rewind
        '{OP_HELD,      tart_pkg::REG_DATA,   8'h00,  8'h00},
        '{OP_WRITE,     tart_pkg::REG_CTRL,   8'h00,  8'h00},   // Fake data run
        '{OP_WRITE,     tart_pkg::REG_CTRL,   C_FAKE, 8'h00},
        '{OP_POLL,      tart_pkg::REG_STATUS, FULL_M, 8'h00},
        '{OP_MASK,      tart_pkg::REG_STATUS, OVF_M | ACQ_M, 8'h00},
        '{OP_WRITE,     tart_pkg::REG_DATA,   8'h00,  8'h00},
        '{OP_CHAIN,     tart_pkg::REG_DATA,   8'h00,  8'h00},
        '{OP_WRITE,     tart_pkg::REG_CTRL,   8'h00,  8'h00},   // Host reads contend
        '{OP_WRITE,     tart_pkg::REG_CTRL,   C_FAKE, 8'h00},
        '{OP_WRITE,     tart_pkg::REG_DATA,   8'h00,  8'h00},
        '{OP_CONTEND,   tart_pkg::REG_DATA,   FULL_M, 8'h00},
        '{OP_MASK,      tart_pkg::REG_STATUS, OVF_M | ACQ_M, 8'h00},
        '{OP_WRITE,     tart_pkg::REG_DATA,   8'h00,  8'h00},
        '{OP_CHAIN,     tart_pkg::REG_DATA,   8'h00,  8'h00},
        '{OP_WRITE,     tart_pkg::REG_CTRL,   C_STOP, 8'h00},   // Re-arm
        '{OP_WRITE,     tart_pkg::REG_CTRL,   C_FAKE, 8'h00},
        '{OP_MASK,      tart_pkg::REG_COUNT,  CNT_HI, 8'h00},   // Below depth
        '{OP_MASK,      tart_pkg::REG_STATUS, FULL_M | ACQ_M, ACQ_M}   // Running, not full
    };

    tart_top #(.SAMPLE_DIV(SAMPLE_DIV), .DEPTH_LOG2(DEPTH_LOG2)) i_dut (
        .clock_b      (clock_b),
        .rst_i        (rst_i),
        .antenna_i    (antenna_i),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o)
    );

    initial begin
        clock_b = 1'b0;
        forever #10 clock_b = ~clock_b;
    end

    // Reference Galois step with tap mask 8'hB8 and right shift
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic check_equal(input string name, input logic [7:0] got,
                               input logic [7:0] exp_val);
        if (got !== exp_val) begin
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp_val);
            $display("Result: FAILED");
            $fatal;
        end
    endtask

    // ------------------------------------------------------------------
    // Host four-phase access with inputs changed 2 units after the edge
    // ------------------------------------------------------------------
    task automatic host_access(input logic we, input tart_pkg::reg_addr_e addr,
                               input tart_pkg::reg_data_t wdata,
                               output tart_pkg::reg_data_t rdata);
        host_we_i    = we;
        host_addr_i  = addr;
        host_wdata_i = wdata;
        host_req_i   = 1'b1;
        do begin
            @(posedge clock_b);
            #2;
        end while (!host_ack_o);
        rdata      = host_rdata_o;      // Valid while ack high
        host_req_i = 1'b0;
        do begin
            @(posedge clock_b);
            #2;
        end while (host_ack_o);
    endtask

    task automatic host_write(input tart_pkg::reg_addr_e addr, input tart_pkg::reg_data_t wdata);
        tart_pkg::reg_data_t unused;
        host_access(1'b1, addr, wdata, unused);
    endtask

    task automatic host_read(input tart_pkg::reg_addr_e addr, output tart_pkg::reg_data_t rdata);
        host_access(1'b0, addr, 8'h00, rdata);
    endtask

    task automatic run_row(input row_t r);
        tart_pkg::reg_data_t rd;
        tart_pkg::reg_data_t prev;
        tart_pkg::reg_data_t val;
        int                  i;
        prev = 8'h00;
        case (r.op)
            OP_WRITE: host_write(r.addr, r.data);
            OP_READ: begin
                host_read(r.addr, rd);
                check_equal($sformatf("host_rdata_o %s", r.addr.name()), rd, r.exp_val);
            end
            OP_MASK: begin
                host_read(r.addr, rd);
                check_equal($sformatf("host_rdata_o %s masked", r.addr.name()),
                            rd & r.data, r.exp_val);
            end
            OP_POLL: begin
                do host_read(r.addr, rd); while ((rd & r.data) == 8'h00);
            end
            OP_RAND_CTRL: begin
                val = 8'($urandom % 4);             // ACQ_EN stays clear
                host_write(tart_pkg::REG_CTRL, val);
                host_read(tart_pkg::REG_CTRL, rd);
                check_equal("host_rdata_o REG_CTRL", rd, val);
            end
            OP_HELD: begin
                for (i = 0; i < DEPTH; i++) begin
                    host_read(tart_pkg::REG_DATA, rd);
                    check_equal("host_rdata_o REG_DATA", rd, ant_val);
                end
            end
            OP_CHAIN: begin
                for (i = 0; i < DEPTH; i++) begin
                    host_read(tart_pkg::REG_DATA, rd);
                    check_equal("REG_DATA nonzero", (rd != 8'h00) ? 8'h01 : 8'h00, 8'h01);
                    if (i > 0) check_equal("host_rdata_o REG_DATA chain", rd, lfsr_next(prev));
                    prev = rd;
                end
            end
            OP_CONTEND: begin
                do begin
                    host_read(tart_pkg::REG_DATA, rd);      // Contends with acquire
                    host_read(tart_pkg::REG_STATUS, rd);
                end while ((rd & r.data) == 8'h00);
            end
            default: begin
                $display("Error: the stimulus table holds an unknown operation");
                $display("Result: FAILED");
                $fatal;
            end
        endcase
    endtask

    // ------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        int n;
        void'($urandom(28));
        ant_val      = tart_pkg::antenna_t'($urandom);
        antenna_i    = ant_val;
        rst_i        = 1'b1;
        host_req_i   = 1'b0;
        host_we_i    = 1'b0;
        host_addr_i  = tart_pkg::REG_CTRL;
        host_wdata_i = 8'h00;
        repeat (10) @(posedge clock_b);
        #2;
        rst_i = 1'b0;
        for (n = 0; n < NROWS; n++) begin
            run_row(rows[n]);
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(20 * (10 + NROWS * DEPTH * SAMPLE_DIV * 4));
        $display("Timeout: the table did not finish in the allowed time");
        $display("Result: FAILED");
        $fatal;
    end

endmodule

/* design/tart_top.sv */
module tart_top #(
    parameter int SAMPLE_DIV = 8,             // At least 8 for one write per strobe
    parameter int DEPTH_LOG2 = 4              // 16-sample buffer
) (
    input  logic                clock_b,
    input  logic                rst_i,
    input  tart_pkg::antenna_t  antenna_i,
    input  logic                host_req_i,
    input  logic                host_we_i,
    input  tart_pkg::reg_addr_e host_addr_i,
    input  tart_pkg::reg_data_t host_wdata_i,
    output logic                host_ack_o,
    output tart_pkg::reg_data_t host_rdata_o
);

    logic                 cap_en, fake, acq_en, arm;
    logic                 strobe;
    tart_pkg::antenna_t   sample;
    logic [DEPTH_LOG2:0]  count;
    logic                 full, overflow, acquiring;

    // Buffer master ports
    tart_buf_if #(.DEPTH_LOG2(DEPTH_LOG2)) acq_bus ();
    tart_buf_if #(.DEPTH_LOG2(DEPTH_LOG2)) host_bus ();

    // ------------------------------------------------------------------
    // Sampling path
    // ------------------------------------------------------------------
    tart_capture #(.SAMPLE_DIV(SAMPLE_DIV)) u_capture (
        .clock_b   (clock_b),
        .rst_i     (rst_i),
        .cap_en_i  (cap_en),
        .fake_i    (fake),
        .antenna_i (antenna_i),
        .strobe_o  (strobe),
        .sample_o  (sample)
    );

    tart_acquire #(.DEPTH_LOG2(DEPTH_LOG2)) u_acquire (
        .clock_b     (clock_b),
        .rst_i       (rst_i),
        .acq_en_i    (acq_en),
        .arm_i       (arm),
        .strobe_i    (strobe),
        .sample_i    (sample),
        .buf_port    (acq_bus),
        .count_o     (count),
        .full_o      (full),
        .overflow_o  (overflow),
        .acquiring_o (acquiring)
    );

    // ------------------------------------------------------------------
    // Shared buffer and host side
    // ------------------------------------------------------------------
    tart_buffer_arbiter #(.DEPTH_LOG2(DEPTH_LOG2)) u_arbiter (
        .clock_b   (clock_b),
        .rst_i     (rst_i),
        .acq_port  (acq_bus),
        .host_port (host_bus)
    );

    tart_host_regs #(.DEPTH_LOG2(DEPTH_LOG2)) u_host_regs (
        .clock_b      (clock_b),
        .rst_i        (rst_i),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .buf_port     (host_bus),
        .cap_en_o     (cap_en),
        .fake_o       (fake),
        .acq_en_o     (acq_en),
        .arm_o        (arm),
        .count_i      (count),
        .full_i       (full),
        .overflow_i   (overflow),
        .acquiring_i  (acquiring)
    );

endmodule

/* design/tart_host_regs.sv */
module tart_host_regs #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  clock_b,
    input  logic                  rst_i,
    // Host four-phase port
    input  logic                  host_req_i,
    input  logic                  host_we_i,
    input  tart_pkg::reg_addr_e   host_addr_i,
    input  tart_pkg::reg_data_t   host_wdata_i,
    output logic                  host_ack_o,
    output tart_pkg::reg_data_t   host_rdata_o,
    // Buffer read port
    tart_buf_if.master            buf_port,
    // Control out
    output logic                  cap_en_o,
    output logic                  fake_o,
    output logic                  acq_en_o,
    output logic                  arm_o,        // ACQ_EN rising by write
    // Status in
    input  logic [DEPTH_LOG2:0]   count_i,
    input  logic                  full_i,
    input  logic                  overflow_i,
    input  logic                  acquiring_i
);

    tart_pkg::hreg_state_e   state;
    tart_pkg::reg_data_t     ctrl_r;
    tart_pkg::reg_data_t     status_w;
    tart_pkg::reg_data_t     rdata_r;
    logic [DEPTH_LOG2-1:0]   rd_ptr;            // Next buffer word to read
    logic                    buf_req_r;

    assign cap_en_o = ctrl_r[tart_pkg::CTRL_CAP_EN];
    assign fake_o   = ctrl_r[tart_pkg::CTRL_FAKE];
    assign acq_en_o = ctrl_r[tart_pkg::CTRL_ACQ_EN];

    always_comb begin
        status_w = '0;
        status_w[tart_pkg::STAT_FULL]      = full_i;
        status_w[tart_pkg::STAT_ACQUIRING] = acquiring_i;
        status_w[tart_pkg::STAT_OVERFLOW]  = overflow_i;
    end

    // Read-only master, pointer holds until ack falls
    assign buf_port.req   = buf_req_r;
    assign buf_port.we    = 1'b0;
    assign buf_port.addr  = rd_ptr;
    assign buf_port.wdata = '0;

    assign host_rdata_o = rdata_r;

    // ------------------------------------------------------------------
    // Host access FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (rst_i) begin
            state      <= tart_pkg::HR_IDLE;
            host_ack_o <= 1'b0;
            buf_req_r  <= 1'b0;
            ctrl_r     <= '0;
            rdata_r    <= '0;
            rd_ptr     <= '0;
            arm_o      <= 1'b0;
        end else begin
            arm_o <= 1'b0;
            case (state)
                tart_pkg::HR_IDLE: begin
                    if (host_req_i) begin
                        state <= tart_pkg::HR_ACK;      // Most accesses ack in 2
                        case (host_addr_i)
                            tart_pkg::REG_CTRL: begin
                                rdata_r <= ctrl_r;
                                if (host_we_i) begin
                                    ctrl_r <= host_wdata_i;
                                    arm_o  <= host_wdata_i[tart_pkg::CTRL_ACQ_EN]
                                              && !ctrl_r[tart_pkg::CTRL_ACQ_EN];
                                end
                            end
                            tart_pkg::REG_STATUS: rdata_r <= status_w;  // Writes ignored
                            tart_pkg::REG_COUNT:  rdata_r <= tart_pkg::reg_data_t'(count_i);
                            tart_pkg::REG_DATA: begin
                                if (host_we_i) begin
                                    rd_ptr <= '0;       // Rewind read pointer
                                end else begin
                                    buf_req_r <= 1'b1;
                                    state     <= tart_pkg::HR_BUF;
                                end
                            end
                            default: rdata_r <= '0;
                        endcase
                    end
                end
                tart_pkg::HR_BUF: begin
                    if (buf_req_r) begin
                        if (buf_port.ack) begin
                            rdata_r   <= buf_port.rdata;
                            buf_req_r <= 1'b0;
                        end
                    end else if (!buf_port.ack) begin   // Buffer handshake done
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= tart_pkg::HR_ACK;
                    end
                end
                tart_pkg::HR_ACK: begin
                    if (!host_ack_o) begin
                        host_ack_o <= 1'b1;
                    end else if (!host_req_i) begin
                        host_ack_o <= 1'b0;
                        state      <= tart_pkg::HR_IDLE;
                    end
                end
                default: state <= tart_pkg::HR_IDLE;
            endcase
        end
    end

endmodule

/* design/tart_buffer_arbiter.sv */
module tart_buffer_arbiter #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic        clock_b,
    input  logic        rst_i,
    tart_buf_if.arbiter acq_port,       // Sample writer
    tart_buf_if.arbiter host_port       // Host reader
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    tart_pkg::antenna_t     mem [DEPTH];         // Sample memory
    tart_pkg::antenna_t     rdata_r;
    logic                   busy;                // Ack phase of a transfer
    logic                   sel_host;            // Served master, kept as last served
    logic                   pick_host;
    logic                   g_host;
    logic                   g_req;
    logic                   g_we;
    logic [DEPTH_LOG2-1:0]  g_addr;
    tart_pkg::antenna_t     g_wdata;

    // ------------------------------------------------------------------
    // Round-robin choice
    // ------------------------------------------------------------------
    // Host wins alone, or on a tie when acquire was served last
    assign pick_host = host_port.req && (!acq_port.req || !sel_host);

    // Granted master, frozen while busy
    assign g_host  = busy ? sel_host : pick_host;
    assign g_req   = g_host ? host_port.req   : acq_port.req;
    assign g_we    = g_host ? host_port.we    : acq_port.we;
    assign g_addr  = g_host ? host_port.addr  : acq_port.addr;
    assign g_wdata = g_host ? host_port.wdata : acq_port.wdata;

    // ------------------------------------------------------------------
    // Grant and ack sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (rst_i) begin
            busy     <= 1'b0;
            sel_host <= 1'b0;
        end else if (!busy) begin
            if (g_req) begin                     // Grant, ack next cycle
                busy     <= 1'b1;
                sel_host <= pick_host;
            end
        end else if (!g_req) begin
            busy <= 1'b0;                        // Ack drops after req low
        end
    end

    // Memory access on the grant edge
    always_ff @(posedge clock_b) begin
        if (!busy && g_req) begin
            if (g_we) begin
                mem[g_addr] <= g_wdata;
            end
            rdata_r <= mem[g_addr];
        end
    end

    // Route ack to the served master only
    assign acq_port.ack    = busy && !sel_host;
    assign host_port.ack   = busy && sel_host;
    assign acq_port.rdata  = rdata_r;
    assign host_port.rdata = rdata_r;

endmodule

/* design/tart_acquire.sv */
module tart_acquire #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic               clock_b,
    input  logic               rst_i,
    input  logic               acq_en_i,       // Acquisition enabled level
    input  logic               arm_i,          // Start of a new run
    input  logic               strobe_i,
    input  tart_pkg::antenna_t sample_i,
    tart_buf_if.master         buf_port,       // Write port to the buffer
    output logic [DEPTH_LOG2:0] count_o,       // Samples stored this run
    output logic               full_o,
    output logic               overflow_o,     // A strobe was dropped
    output logic               acquiring_o
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    tart_pkg::acq_state_e   state;
    tart_pkg::antenna_t     wdata_r;           // Pending sample
    logic [DEPTH_LOG2-1:0]  addr_r;            // Its buffer slot

    // Write-only master
    assign buf_port.req   = (state == tart_pkg::ACQ_REQ);
    assign buf_port.we    = 1'b1;
    assign buf_port.addr  = addr_r;
    assign buf_port.wdata = wdata_r;

    assign acquiring_o = (state != tart_pkg::ACQ_IDLE);

    // ------------------------------------------------------------------
    // Control FSM, count and flags
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (rst_i) begin
            state      <= tart_pkg::ACQ_IDLE;
            count_o    <= '0;
            full_o     <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            if (arm_i) begin                   // New run starts empty
                count_o    <= '0;
                full_o     <= 1'b0;
                overflow_o <= 1'b0;
            end
            case (state)
                tart_pkg::ACQ_IDLE: begin
                    if (arm_i) state <= tart_pkg::ACQ_WAIT;
                end
                tart_pkg::ACQ_WAIT: begin
                    if (!acq_en_i) begin
                        state <= tart_pkg::ACQ_IDLE;
                    end else if (strobe_i) begin
                        state <= tart_pkg::ACQ_REQ;
                    end
                end
                tart_pkg::ACQ_REQ: begin
                    if (strobe_i) overflow_o <= 1'b1;  // Write still pending
                    if (buf_port.ack) begin
                        count_o <= count_o + 1'b1;
                        full_o  <= (count_o + 1'b1 == (DEPTH_LOG2 + 1)'(DEPTH));
                        state   <= tart_pkg::ACQ_DONE;
                    end
                end
                tart_pkg::ACQ_DONE: begin
                    if (strobe_i) overflow_o <= 1'b1;
                    if (!buf_port.ack) begin           // Handshake closed
                        state <= (acq_en_i && !full_o) ? tart_pkg::ACQ_WAIT
                                                       : tart_pkg::ACQ_IDLE;
                    end
                end
                default: state <= tart_pkg::ACQ_IDLE;
            endcase
        end
    end

    // Latch the sample and its slot on an accepted strobe
    always_ff @(posedge clock_b) begin
        if (state == tart_pkg::ACQ_WAIT && acq_en_i && strobe_i) begin
            wdata_r <= sample_i;
            addr_r  <= count_o[DEPTH_LOG2-1:0];
        end
    end

endmodule

/* design/tart_capture.sv */
module tart_capture #(
    parameter int SAMPLE_DIV = 8              // Clocks per sample strobe
) (
    input  logic               clock_b,
    input  logic               rst_i,
    input  logic               cap_en_i,      // Run the strobe divider
    input  logic               fake_i,        // Select LFSR data
    input  tart_pkg::antenna_t antenna_i,     // Raw, asynchronous antenna bits
    output logic               strobe_o,      // One cycle per sample period
    output tart_pkg::antenna_t sample_o       // Valid on strobe
);

    localparam int CW = $clog2(SAMPLE_DIV);

    logic [CW-1:0]      div_cnt;
    tart_pkg::antenna_t ant_s1, ant_s2;       // Two-flop synchronizer
    tart_pkg::antenna_t lfsr;

    // One Galois step, right shift with feedback from bit 0
    function automatic tart_pkg::antenna_t lfsr_step(input tart_pkg::antenna_t s);
        tart_pkg::antenna_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ tart_pkg::LFSR_TAPS;
        end
        return n;
    endfunction

    // ------------------------------------------------------------------
    // Antenna synchronizer
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        ant_s1 <= antenna_i;
        ant_s2 <= ant_s1;
    end

    // ------------------------------------------------------------------
    // Strobe divider and fake data
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (rst_i) begin
            div_cnt  <= '0;
            strobe_o <= 1'b0;
            lfsr     <= tart_pkg::LFSR_SEED;
        end else begin
            strobe_o <= 1'b0;
            if (!cap_en_i) begin
                div_cnt <= '0;                // Restart period when stopped
            end else if (div_cnt == CW'(SAMPLE_DIV - 1)) begin
                div_cnt  <= '0;
                strobe_o <= 1'b1;
                if (fake_i) begin
                    lfsr <= lfsr_step(lfsr);  // New state shows on the strobe
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign sample_o = fake_i ? lfsr : ant_s2;

endmodule

/* design/tart_buf_if.sv */
// Four-phase master port onto the sample buffer
interface tart_buf_if #(
    parameter int DEPTH_LOG2 = 4
);

    logic                   req;       // Master request, held until ack
    logic                   we;        // Write when set, else read
    logic [DEPTH_LOG2-1:0]  addr;      // Buffer word address
    tart_pkg::antenna_t     wdata;     // Write sample
    logic                   ack;       // Arbiter acknowledge
    tart_pkg::antenna_t     rdata;     // Read sample, valid with ack

    // Requesting side
    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    // Serving side
    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

/* design/tart_pkg.sv */
package tart_pkg;

    // ------------------------------------------------------------------
    // Antenna sample and host bus widths
    // ------------------------------------------------------------------
    localparam int NANT = 8;                  // Antenna bits per sample

    typedef logic [NANT-1:0] antenna_t;       // One sample, all antennas
    typedef logic [7:0]      reg_data_t;      // Host data word

    // Host register map
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,                    // Control, read/write
        REG_STATUS = 2'd1,                    // Status, read only
        REG_COUNT  = 2'd2,                    // Stored sample count
        REG_DATA   = 2'd3                     // Buffer read port
    } reg_addr_e;

    // Control register bits
    localparam int CTRL_CAP_EN = 0;           // Sample strobe running
    localparam int CTRL_FAKE   = 1;           // LFSR instead of antennas
    localparam int CTRL_ACQ_EN = 2;           // Store samples to buffer

    // Status register bits
    localparam int STAT_FULL      = 0;
    localparam int STAT_ACQUIRING = 1;
    localparam int STAT_OVERFLOW  = 2;

    // Galois LFSR for x^8+x^6+x^5+x^4+1, shifting right
    localparam antenna_t LFSR_TAPS = 8'hB8;
    localparam antenna_t LFSR_SEED = 8'h01;   // Must never be zero

    // ------------------------------------------------------------------
    // State encodings
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {ACQ_IDLE, ACQ_WAIT, ACQ_REQ, ACQ_DONE} acq_state_e;

    typedef enum logic [1:0] {HR_IDLE, HR_BUF, HR_ACK} hreg_state_e;

endpackage
